// File: Bender.yml
package:
  name: board_base

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/board_pkg.sv
      - design/mmc_spi_bridge.sv
      - design/uart_cmd_bridge.sv
      - design/reg_bus_arbiter.sv
      - design/board_regs.sv
      - design/phy_reset_seq.sv
      - design/board_base.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/tb_clock_gen.sv
      - tests/board_base_tb.sv

// File: design/board_base.sv
/* Portable board control plane in the tx_clk domain
   SPI and UART masters share the register file through one arbiter */
module board_base (
	input  logic                 tx_clk,
	input  logic                 rst_n,
	input  logic                 clk_locked,
	input  logic                 sclk,
	input  logic                 csb,
	input  logic                 mosi,
	output logic                 miso,
	input  logic                 fpga_txd,
	output logic                 fpga_rxd,
	output logic                 phy_rstn,
	output logic                 vcxo_en,
	output logic                 tmds_enable,
	output board_pkg::reg_data_t led
);
	import board_pkg::*;

	logic spi_req;
	logic spi_we;
	logic spi_ack;
	reg_addr_t spi_addr;
	reg_data_t spi_wdata;
	reg_data_t spi_rdata;
	logic uart_req;
	logic uart_we;
	logic uart_ack;
	reg_addr_t uart_addr;
	reg_data_t uart_wdata;
	reg_data_t uart_rdata;
	logic reg_en;
	logic reg_we;
	reg_addr_t reg_addr;
	reg_data_t reg_wdata;
	reg_data_t reg_rdata;
	logic phy_rst_req;

	// Microcontroller side
	mmc_spi_bridge spi_bridge (
		.tx_clk(tx_clk), .rst_n(rst_n),
		.sclk(sclk), .csb(csb), .mosi(mosi), .miso(miso),
		.req(spi_req), .we(spi_we), .addr(spi_addr), .wdata(spi_wdata),
		.ack(spi_ack), .rdata(spi_rdata)
	);

	// USB UART side
	uart_cmd_bridge uart_bridge (
		.tx_clk(tx_clk), .rst_n(rst_n),
		.fpga_txd(fpga_txd), .fpga_rxd(fpga_rxd),
		.req(uart_req), .we(uart_we), .addr(uart_addr), .wdata(uart_wdata),
		.ack(uart_ack), .rdata(uart_rdata)
	);

	reg_bus_arbiter arbiter (
		.tx_clk(tx_clk), .rst_n(rst_n),
		.spi_req(spi_req), .spi_we(spi_we), .spi_addr(spi_addr),
		.spi_wdata(spi_wdata), .spi_ack(spi_ack), .spi_rdata(spi_rdata),
		.uart_req(uart_req), .uart_we(uart_we), .uart_addr(uart_addr),
		.uart_wdata(uart_wdata), .uart_ack(uart_ack), .uart_rdata(uart_rdata),
		.reg_en(reg_en), .reg_we(reg_we), .reg_addr(reg_addr),
		.reg_wdata(reg_wdata), .reg_rdata(reg_rdata)
	);

	board_regs regs (
		.tx_clk(tx_clk), .rst_n(rst_n),
		.reg_en(reg_en), .reg_we(reg_we), .reg_addr(reg_addr),
		.reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
		.clk_locked(clk_locked), .phy_rstn(phy_rstn),
		.led(led), .vcxo_en(vcxo_en), .tmds_enable(tmds_enable),
		.phy_rst_req(phy_rst_req)
	);

	phy_reset_seq phy_seq (
		.tx_clk(tx_clk), .rst_n(rst_n),
		.clk_locked(clk_locked), .phy_rst_req(phy_rst_req),
		.phy_rstn(phy_rstn)
	);

endmodule

// File: design/board_pkg.sv
/* Register bus types, register map and UART command bytes
   Map entries past REG_SCRATCH read as zero */
`include "board_settings.svh"

package board_pkg;

	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [`REG_DATA_W-1:0] reg_data_t;

	// Register map
	typedef enum logic [`REG_ADDR_W-1:0] {
		REG_ID         = 0,
		REG_STATUS     = 1,
		REG_EXT_CONFIG = 2,
		REG_LED        = 3,
		REG_SCRATCH    = 4
	} reg_index_e;

	// First byte of a UART command
	typedef enum logic [7:0] {
		CMD_READ  = 8'h52,
		CMD_WRITE = 8'h57
	} uart_cmd_e;

endpackage

// File: design/board_regs.sv
/* Board control registers on an 8-bit bus with combinational read data
   Writes to read-only or unmapped addresses are dropped */
`include "board_settings.svh"

module board_regs (
	input  logic                 tx_clk,
	input  logic                 rst_n,
	input  logic                 reg_en,
	input  logic                 reg_we,
	input  board_pkg::reg_addr_t reg_addr,
	input  board_pkg::reg_data_t reg_wdata,
	output board_pkg::reg_data_t reg_rdata,
	input  logic                 clk_locked,
	input  logic                 phy_rstn,
	output board_pkg::reg_data_t led,
	output logic                 vcxo_en,
	output logic                 tmds_enable,
	output logic                 phy_rst_req
);
	import board_pkg::*;

	reg_data_t ext_config;
	reg_data_t scratch;

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			ext_config <= `EXT_CONFIG_DEFAULT;
			led <= '0;
			scratch <= '0;
		end else if (reg_en && reg_we) begin
			case (reg_addr)
				REG_EXT_CONFIG: ext_config <= reg_wdata;
				REG_LED:        led <= reg_wdata;
				REG_SCRATCH:    scratch <= reg_wdata;
				default:        ;
			endcase
		end
	end

	always_comb begin
		case (reg_addr)
			REG_ID:         reg_rdata = `BOARD_ID;
			REG_STATUS:     reg_rdata = {{(`REG_DATA_W - 2){1'b0}}, phy_rstn, clk_locked};
			REG_EXT_CONFIG: reg_rdata = ext_config;
			REG_LED:        reg_rdata = led;
			REG_SCRATCH:    reg_rdata = scratch;
			default:        reg_rdata = '0;
		endcase
	end

	// Board controls from ext_config
	assign tmds_enable = ext_config[0];
	assign vcxo_en = ~ext_config[1];
	assign phy_rst_req = ext_config[2];

endmodule

// File: design/board_settings.svh
/* Build constants shared by the RTL and the testbench
   UART_CLKS_PER_BIT must be even and at least 4 */
`ifndef BOARD_SETTINGS_SVH
`define BOARD_SETTINGS_SVH

// Register bus geometry
`define REG_ADDR_W 4
`define REG_DATA_W 8

// Read-only identification byte at address 0
`define BOARD_ID 8'hA5

// TMDS on, VCXO on, no PHY reset request
`define EXT_CONFIG_DEFAULT 8'h01

// tx_clk cycles per UART bit
`define UART_CLKS_PER_BIT 16

// PHY reset hold after clock lock
`define PHY_RST_CYCLES 32

`endif

// File: design/mmc_spi_bridge.sv
/* SPI mode 0 slave, 16-bit frames, sampled on tx_clk
   sclk half-periods must be 16 or more tx_clk cycles for read data to be ready */
module mmc_spi_bridge (
	input  logic                 tx_clk,
	input  logic                 rst_n,
	input  logic                 sclk,
	input  logic                 csb,
	input  logic                 mosi,
	input  logic                 ack,
	input  board_pkg::reg_data_t rdata,
	output logic                 miso,
	output logic                 req,
	output logic                 we,
	output board_pkg::reg_addr_t addr,
	output board_pkg::reg_data_t wdata
);
	import board_pkg::*;

	logic [2:0] sclk_q;
	logic [1:0] csb_q;
	logic [1:0] mosi_q;
	logic sclk_rise;
	logic sclk_fall;
	logic active;
	logic [4:0] bit_cnt;
	logic [14:0] shift_in;
	logic [15:0] frame;
	logic hdr_read;
	logic frm_write;
	logic out_phase;
	reg_data_t out_shift;

	assign active = !csb_q[1];
	assign sclk_rise = active && sclk_q[1] && !sclk_q[2];
	assign sclk_fall = active && !sclk_q[1] && sclk_q[2];
	// Frame including the bit being sampled now
	assign frame = {shift_in, mosi_q[1]};
	assign hdr_read = sclk_rise && bit_cnt == 5'd7 && frame[7];
	assign frm_write = sclk_rise && bit_cnt == 5'd15 && !frame[15];
	// Read byte goes out during bits 8 to 15
	assign out_phase = bit_cnt >= 5'd8 && bit_cnt <= 5'd15;

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			sclk_q <= 3'b000;
			csb_q <= 2'b11;
			mosi_q <= 2'b00;
			bit_cnt <= '0;
			miso <= 1'b0;
			req <= 1'b0;
		end else begin
			sclk_q <= {sclk_q[1:0], sclk};
			csb_q <= {csb_q[0], csb};
			mosi_q <= {mosi_q[0], mosi};
			if (ack) begin
				req <= 1'b0;
			end
			if (hdr_read || frm_write) begin
				req <= 1'b1;
			end
			if (!active) begin
				// Abort, a pending request still completes
				bit_cnt <= '0;
				miso <= 1'b0;
			end else if (sclk_rise && bit_cnt != 5'd16) begin
				bit_cnt <= bit_cnt + 5'd1;
			end else if (sclk_fall) begin
				miso <= out_phase ? out_shift[7] : 1'b0;
			end
		end
	end

	always_ff @(posedge tx_clk) begin
		if (sclk_rise) begin
			shift_in <= frame[14:0];
		end
		if (hdr_read) begin
			we <= 1'b0;
			addr <= frame[3:0];
		end else if (frm_write) begin
			we <= 1'b1;
			addr <= frame[11:8];
			wdata <= frame[7:0];
		end
		if (ack && !we) begin
			out_shift <= rdata;
		end else if (sclk_rise && bit_cnt == 5'd7) begin
			out_shift <= '0;
		end else if (sclk_fall && out_phase) begin
			out_shift <= {out_shift[6:0], 1'b0};
		end
	end

endmodule

// File: design/phy_reset_seq.sv
/* PHY reset release, PHY_RST_CYCLES after lock with no reset request
   clk_locked is taken as already in the tx_clk domain */
`include "board_settings.svh"

module phy_reset_seq (
	input  logic tx_clk,
	input  logic rst_n,
	input  logic clk_locked,
	input  logic phy_rst_req,
	output logic phy_rstn
);
	localparam int CNT_W = $clog2(`PHY_RST_CYCLES);
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(`PHY_RST_CYCLES - 1);

	logic release_ok;
	logic [CNT_W-1:0] count;

	assign release_ok = clk_locked && !phy_rst_req;

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			count <= RELOAD;
			phy_rstn <= 1'b0;
		end else if (!release_ok) begin
			// Any failed condition restarts the hold
			count <= RELOAD;
			phy_rstn <= 1'b0;
		end else if (count != '0) begin
			count <= count - 1'b1;
		end else begin
			phy_rstn <= 1'b1;
		end
	end

endmodule

// File: design/reg_bus_arbiter.sv
/* Two-master round-robin arbiter for the register port, one access in flight
   Masters must drop req in the cycle after ack */
module reg_bus_arbiter (
	input  logic                 tx_clk,
	input  logic                 rst_n,
	input  logic                 spi_req,
	input  logic                 spi_we,
	input  board_pkg::reg_addr_t spi_addr,
	input  board_pkg::reg_data_t spi_wdata,
	output logic                 spi_ack,
	output board_pkg::reg_data_t spi_rdata,
	input  logic                 uart_req,
	input  logic                 uart_we,
	input  board_pkg::reg_addr_t uart_addr,
	input  board_pkg::reg_data_t uart_wdata,
	output logic                 uart_ack,
	output board_pkg::reg_data_t uart_rdata,
	output logic                 reg_en,
	output logic                 reg_we,
	output board_pkg::reg_addr_t reg_addr,
	output board_pkg::reg_data_t reg_wdata,
	input  board_pkg::reg_data_t reg_rdata
);
	import board_pkg::*;

	// Last winner, also routes ack for the access in flight
	logic gnt_uart;
	logic idle;
	logic pick_uart;
	reg_data_t rdata_q;

	// No grant while an access or its ack is under way
	assign idle = !reg_en && !spi_ack && !uart_ack;
	assign pick_uart = uart_req && (!spi_req || !gnt_uart);
	assign spi_rdata = rdata_q;
	assign uart_rdata = rdata_q;

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			reg_en <= 1'b0;
			spi_ack <= 1'b0;
			uart_ack <= 1'b0;
			gnt_uart <= 1'b0;
		end else begin
			spi_ack <= reg_en && !gnt_uart;
			uart_ack <= reg_en && gnt_uart;
			reg_en <= idle && (spi_req || uart_req);
			if (idle && (spi_req || uart_req)) begin
				gnt_uart <= pick_uart;
			end
		end
	end

	always_ff @(posedge tx_clk) begin
		if (idle) begin
			reg_we <= pick_uart ? uart_we : spi_we;
			reg_addr <= pick_uart ? uart_addr : spi_addr;
			reg_wdata <= pick_uart ? uart_wdata : spi_wdata;
		end
		if (reg_en) begin
			rdata_q <= reg_rdata;
		end
	end

endmodule

// File: design/uart_cmd_bridge.sv
/* 8N1 UART command bridge: 'W' addr data writes, 'R' addr reads and replies
   A read reply is sent only if the transmitter is idle when ack arrives */
`include "board_settings.svh"

module uart_cmd_bridge (
	input  logic                 tx_clk,
	input  logic                 rst_n,
	input  logic                 fpga_txd,
	input  logic                 ack,
	input  board_pkg::reg_data_t rdata,
	output logic                 fpga_rxd,
	output logic                 req,
	output logic                 we,
	output board_pkg::reg_addr_t addr,
	output board_pkg::reg_data_t wdata
);
	import board_pkg::*;

	localparam int CLKS = `UART_CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CLKS);

	typedef enum logic [1:0] {P_CMD, P_ADDR, P_DATA} parse_e;

	logic [1:0] rxd_q;
	logic rxd;
	logic rx_busy;
	logic [CNT_W-1:0] rx_cnt;
	logic [3:0] rx_bit;
	logic rx_tick;
	logic rx_sample;
	logic rx_valid;
	logic [7:0] rx_shift;
	parse_e state;
	logic is_write;
	logic [CNT_W-1:0] tx_cnt;
	logic [3:0] tx_left;
	logic [9:0] tx_shift;
	logic tx_start;
	logic tx_step;

	assign rxd = rxd_q[1];
	assign rx_tick = rx_busy && rx_cnt == '0;
	// Data bits are 1 to 8, LSB first
	assign rx_sample = rx_tick && rx_bit != 4'd0 && rx_bit != 4'd9;
	assign tx_step = tx_cnt == '0 && tx_left != 4'd0;
	assign tx_start = tx_cnt == '0 && tx_left == 4'd0 && ack && !we;

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			rxd_q <= 2'b11;
			rx_busy <= 1'b0;
			rx_cnt <= '0;
			rx_bit <= '0;
			rx_valid <= 1'b0;
			state <= P_CMD;
			is_write <= 1'b0;
			req <= 1'b0;
			tx_cnt <= '0;
			tx_left <= '0;
			fpga_rxd <= 1'b1;
		end else begin
			rxd_q <= {rxd_q[0], fpga_txd};
			rx_valid <= 1'b0;
			if (!rx_busy) begin
				if (!rxd) begin
					rx_busy <= 1'b1;
					rx_cnt <= CNT_W'(CLKS / 2 - 1);
					rx_bit <= '0;
				end
			end else if (rx_cnt != '0) begin
				rx_cnt <= rx_cnt - 1'b1;
			end else begin
				rx_cnt <= CNT_W'(CLKS - 1);
				rx_bit <= rx_bit + 4'd1;
				// Start bit high again at mid-bit is a glitch
				if (rx_bit == 4'd0 && rxd) begin
					rx_busy <= 1'b0;
				end
				if (rx_bit == 4'd9) begin
					rx_busy <= 1'b0;
					rx_valid <= rxd;
				end
			end

			if (ack) begin
				req <= 1'b0;
			end
			if (rx_valid) begin
				case (state)
					P_CMD: begin
						if (rx_shift == CMD_WRITE) begin
							is_write <= 1'b1;
							state <= P_ADDR;
						end else if (rx_shift == CMD_READ) begin
							is_write <= 1'b0;
							state <= P_ADDR;
						end
					end
					P_ADDR: begin
						if (is_write) begin
							state <= P_DATA;
						end else begin
							state <= P_CMD;
							req <= 1'b1;
						end
					end
					default: begin
						state <= P_CMD;
						req <= 1'b1;
					end
				endcase
			end

			if (tx_cnt != '0) begin
				tx_cnt <= tx_cnt - 1'b1;
			end else if (tx_step) begin
				fpga_rxd <= tx_shift[0];
				tx_left <= tx_left - 4'd1;
				tx_cnt <= CNT_W'(CLKS - 1);
			end else if (tx_start) begin
				tx_left <= 4'd10;
			end
		end
	end

	always_ff @(posedge tx_clk) begin
		if (rx_sample) begin
			rx_shift <= {rxd, rx_shift[7:1]};
		end
		if (rx_valid && state == P_ADDR) begin
			addr <= reg_addr_t'(rx_shift);
			we <= is_write;
		end
		if (rx_valid && state == P_DATA) begin
			wdata <= rx_shift;
		end
		// Stop, data, start; shifted out from bit 0
		if (tx_start) begin
			tx_shift <= {1'b1, rdata, 1'b0};
		end else if (tx_step) begin
			tx_shift <= {1'b1, tx_shift[9:1]};
		end
	end

endmodule

// File: filelist.f
+incdir+design
design/board_pkg.sv
design/mmc_spi_bridge.sv
design/uart_cmd_bridge.sv
design/reg_bus_arbiter.sv
design/board_regs.sv
design/phy_reset_seq.sv
design/board_base.sv
tests/tb_clock_gen.sv
tests/board_base_tb.sv

// File: tests/board_base_tb.sv
/* Directed testbench for board_base through its SPI, UART and board pins
   Inputs change 1 unit after the rising tx_clk edge and outputs are sampled there */
`include "board_settings.svh"

module board_base_tb;
	import board_pkg::*;

	localparam int CLKS = `UART_CLKS_PER_BIT;
	// SPI half period in tx_clk cycles
	localparam int SPI_HALF = 16;
	// About 20k cycles of SPI frames, UART bytes and waits at 8 units each, plus margin
	localparam int WATCHDOG_TIME = 200000;

	logic tx_clk;
	logic rst_n;
	logic clk_locked;
	logic sclk;
	logic csb;
	logic mosi;
	logic miso;
	logic fpga_txd;
	logic fpga_rxd;
	logic phy_rstn;
	logic vcxo_en;
	logic tmds_enable;
	reg_data_t led;
	int checks;
	int errors;
	logic [31:0] lcg_state = 32'he169;

	tb_clock_gen clock_gen (.tx_clk(tx_clk), .rst_n(rst_n));

	board_base UUT (
		.tx_clk(tx_clk), .rst_n(rst_n), .clk_locked(clk_locked),
		.sclk(sclk), .csb(csb), .mosi(mosi), .miso(miso),
		.fpga_txd(fpga_txd), .fpga_rxd(fpga_rxd), .phy_rstn(phy_rstn),
		.vcxo_en(vcxo_en), .tmds_enable(tmds_enable), .led(led)
	);

	function automatic reg_data_t rand_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge tx_clk);
		#1;
	endtask

	task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Mode 0 frame with miso taken just before each rising sclk of bits 8 to 15
	task automatic spi_xfer(input logic [15:0] frame, output reg_data_t rd);
		reg_data_t sampled;
		sampled = '0;
		csb = 1'b0;
		for (int i = 15; i >= 0; i--) begin
			mosi = frame[i];
			wait_cycles(SPI_HALF);
			if (i <= 7) begin
				sampled = {sampled[6:0], miso};
			end
			sclk = 1'b1;
			wait_cycles(SPI_HALF);
			sclk = 1'b0;
		end
		wait_cycles(SPI_HALF);
		csb = 1'b1;
		mosi = 1'b0;
		wait_cycles(SPI_HALF);
		rd = sampled;
	endtask

	task automatic spi_write(input reg_addr_t a, input reg_data_t d);
		reg_data_t unused;
		spi_xfer({4'b0000, a, d}, unused);
	endtask

	task automatic spi_read(input reg_addr_t a, output reg_data_t d);
		spi_xfer({4'b1000, a, 8'h00}, d);
	endtask

	task automatic uart_send(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			fpga_txd = bits[i];
			wait_cycles(CLKS);
		end
	endtask

	// Waits up to max_wait cycles for a start bit, then samples mid-bit
	task automatic uart_recv(input int max_wait, output reg_data_t b, output bit got);
		int n;
		n = 0;
		b = '0;
		got = 1'b0;
		while (fpga_rxd === 1'b1 && n < max_wait) begin
			wait_cycles(1);
			n++;
		end
		if (fpga_rxd === 1'b0) begin
			got = 1'b1;
			wait_cycles(CLKS / 2);
			for (int i = 0; i < 8; i++) begin
				wait_cycles(CLKS);
				b[i] = fpga_rxd;
			end
			wait_cycles(CLKS);
			check_value("UART reply stop bit", fpga_rxd, 1'b1);
			wait_cycles(CLKS / 2);
		end
	endtask

	task automatic uart_write(input reg_addr_t a, input reg_data_t d);
		uart_send(CMD_WRITE);
		uart_send(8'(a));
		uart_send(d);
	endtask

	// The reply may start during the stop bit of the address byte
	task automatic uart_read(input reg_addr_t a, output reg_data_t d);
		bit got;
		uart_send(CMD_READ);
		fork
			uart_send(8'(a));
			uart_recv(3 * 10 * CLKS, d, got);
		join
		checks++;
		assert (got) else begin
			errors++;
			$display("No UART reply came back for a read of address %0d", a);
		end
	endtask

	task automatic reset_defaults();
		reg_data_t rd;
		check_value("led after reset", led, 8'h00);
		check_value("vcxo_en after reset", vcxo_en, 1'b1);
		check_value("tmds_enable after reset", tmds_enable, 1'b1);
		check_value("phy_rstn after reset", phy_rstn, 1'b0);
		check_value("fpga_rxd idle", fpga_rxd, 1'b1);
		check_value("miso idle", miso, 1'b0);
		spi_read(REG_ID, rd);
		check_value("REG_ID", rd, `BOARD_ID);
		spi_read(REG_EXT_CONFIG, rd);
		check_value("REG_EXT_CONFIG after reset", rd, `EXT_CONFIG_DEFAULT);
	endtask

	task automatic spi_readback();
		reg_data_t led_val;
		reg_data_t scr_val;
		reg_data_t rd;
		reg_addr_t gap_addr;
		led_val = rand_byte();
		scr_val = rand_byte();
		spi_write(REG_LED, led_val);
		spi_write(REG_SCRATCH, scr_val);
		check_value("led port", led, led_val);
		spi_read(REG_LED, rd);
		check_value("REG_LED over SPI", rd, led_val);
		spi_read(REG_SCRATCH, rd);
		check_value("REG_SCRATCH over SPI", rd, scr_val);
		gap_addr = reg_addr_t'(5 + rand_byte() % 11);
		spi_read(gap_addr, rd);
		check_value($sformatf("unmapped address %0d", gap_addr), rd, 8'h00);
		spi_write(REG_ID, rand_byte());
		spi_read(REG_ID, rd);
		check_value("REG_ID after write", rd, `BOARD_ID);
	endtask

	task automatic uart_readback();
		reg_data_t val;
		reg_data_t rd;
		bit got;
		val = rand_byte();
		uart_write(REG_SCRATCH, val);
		uart_read(REG_SCRATCH, rd);
		check_value("REG_SCRATCH over UART", rd, val);
		// Unknown command, then a byte that is no command either
		// A reply would start in the stop bit of the second byte
		fork
			begin
				uart_send(8'h3C);
				uart_send(8'h04);
			end
			uart_recv(4 * 10 * CLKS, rd, got);
		join
		checks++;
		assert (!got) else begin
			errors++;
			$display("A reply byte came back after an unknown UART command");
		end
		uart_read(REG_SCRATCH, rd);
		check_value("REG_SCRATCH after unknown command", rd, val);
	endtask

	task automatic ext_config_decode();
		logic [2:0] p;
		for (int i = 0; i < 8; i++) begin
			// Last pattern is 1 which is the reset value
			p = 3'(i + 2);
			spi_write(REG_EXT_CONFIG, {5'b00000, p});
			check_value($sformatf("tmds_enable for pattern %0d", p), tmds_enable, p[0]);
			check_value($sformatf("vcxo_en for pattern %0d", p), vcxo_en, !p[1]);
		end
	endtask

	task automatic phy_reset_release();
		int n;
		reg_data_t rd;
		wait_cycles(2 * `PHY_RST_CYCLES);
		check_value("phy_rstn while unlocked", phy_rstn, 1'b0);
		clk_locked = 1'b1;
		n = 0;
		while (!phy_rstn && n < 4 * `PHY_RST_CYCLES) begin
			wait_cycles(1);
			n++;
		end
		check_value("cycles from lock to PHY release", n, `PHY_RST_CYCLES);
		// Status bit 0 is clk_locked and bit 1 is phy_rstn
		spi_read(REG_STATUS, rd);
		check_value("REG_STATUS after release", rd, 8'h03);
		spi_write(REG_EXT_CONFIG, 8'h05);
		check_value("phy_rstn with reset requested", phy_rstn, 1'b0);
		spi_read(REG_STATUS, rd);
		check_value("REG_STATUS with reset requested", rd, 8'h01);
		spi_write(REG_EXT_CONFIG, `EXT_CONFIG_DEFAULT);
		n = 0;
		while (!phy_rstn && n < 4 * `PHY_RST_CYCLES) begin
			wait_cycles(1);
			n++;
		end
		check_value("phy_rstn after request cleared", phy_rstn, 1'b1);
	endtask

	task automatic master_contention();
		reg_data_t led_val;
		reg_data_t scr_val;
		reg_data_t rd;
		for (int k = 0; k < 5; k++) begin
			led_val = rand_byte();
			scr_val = rand_byte();
			// Both requests rise near the same cycle for offsets around 23
			fork
				spi_write(REG_LED, led_val);
				begin
					wait_cycles(21 + k);
					uart_write(REG_SCRATCH, scr_val);
				end
			join
			check_value("led after contention", led, led_val);
			spi_read(REG_SCRATCH, rd);
			check_value("REG_SCRATCH after contention", rd, scr_val);
		end
	endtask

	initial begin
		#WATCHDOG_TIME;
		$display("Watchdog expired at %0t before the tests finished", $time);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		clk_locked = 1'b0;
		sclk = 1'b0;
		csb = 1'b1;
		mosi = 1'b0;
		fpga_txd = 1'b1;
		checks = 0;
		errors = 0;
		wait (rst_n === 1'b1);
		wait_cycles(2);
		reset_defaults();
		spi_readback();
		uart_readback();
		ext_config_decode();
		phy_reset_release();
		master_contention();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: tests/tb_clock_gen.sv
/* Free-running tx_clk with an 8-unit period
   rst_n is low for the first 8 rising edges */
module tb_clock_gen (
	output logic tx_clk,
	output logic rst_n
);
	initial begin
		tx_clk = 1'b0;
		forever #4 tx_clk = ~tx_clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge tx_clk);
		#1 rst_n = 1'b1;
	end
endmodule
